// File: rtl/adpcmb_pkg.sv
// adpcmb shared definitions
// widths, sample types, sequencer states and decoder constants
package adpcmb_pkg;

    localparam int pcm_w  = 16;              // decoded sample width
    localparam int step_w = 15;              // adaptive step width
    localparam int addr_w = 16;              // sample memory byte address
    localparam int rate_w = 16;              // delta-n and accumulator

    typedef logic signed [pcm_w-1:0]  pcm_t;
    typedef logic        [step_w-1:0] step_t;
    typedef logic        [3:0]        nibble_t;  // bit 3 sign, bits 2..0 magnitude
    typedef logic        [addr_w-1:0] addr_t;
    typedef logic        [7:0]        byte_t;
    typedef logic        [rate_w-1:0] rate_t;

    typedef enum logic [1:0] {
        st_idle,                             // channel off
        st_fetch,                            // waiting for the first byte
        st_play
    } seq_state_t;

    // frame timing, one ring revolution per frame
    localparam int frame_len = 6;
    localparam int adv_phase = 4;            // stage V holds slot 0 here

    // step limits
    localparam int step_min  = 127;
    localparam int step_init = step_min;
    localparam int step_max  = 24576;

    // sample limits
    localparam int pcm_max = 32767;
    localparam int pcm_min = -32768;

    // step multipliers over 64
    localparam logic [7:0] step_mul_lo = 8'd57;  // magnitudes 0..3
    localparam logic [7:0] step_mul [4] = '{8'd77, 8'd102, 8'd128, 8'd153};

endpackage

// File: rtl/adpcmb_decode.sv
// adpcmb decoder ring
// six stage sample/step loop, slot 0 advances when adv is high at stage V
`timescale 1ns/1ps

module adpcmb_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  adpcmb_pkg::nibble_t code,
    input  logic                chon,      // channel on, sampled with the code
    input  logic                adv,       // stage V update strobe
    output adpcmb_pkg::pcm_t    pcm
);

    // ring of sample and step, one register pair per stage
    adpcmb_pkg::pcm_t  x1, x2, x3, x4, x5, x6;
    adpcmb_pkg::step_t step1, step2, step3, step4, step5, step6;
    logic              chon2, chon3, chon4, chon5;

    // datapath pipeline
    logic [3:0]         mag2;            // odd magnitude 1,3..15
    logic               sign2, sign3;
    logic [15:0]        dlt3;            // unsigned delta, up to 46080
    logic signed [17:0] dlt4;            // signed delta
    logic signed [17:0] sum5;            // wide sum, no wrap
    logic [16:0]        nstep3, nstep4, nstep5;

    // stage II products
    logic [7:0]  mul2;
    logic [18:0] prod2;                  // 4 x 15 bits
    logic [22:0] sprod2;                 // 8 x 15 bits

    always_comb begin
        // magnitude 4..7 picks from the table, lower ones share 57
        if (mag2[3])
            mul2 = adpcmb_pkg::step_mul[mag2[2:1]];
        else
            mul2 = adpcmb_pkg::step_mul_lo;
        prod2  = mag2 * step2;
        sprod2 = mul2 * step2;
    end

    // payload stages I..IV
    always_ff @(posedge clk) begin
        if (cen) begin
            // I odd magnitude
            mag2   <= {code[2:0], 1'b1};
            sign2  <= code[3];
            // II scale by step, /8 for the delta and /64 for the next step
            dlt3   <= prod2[18:3];
            sign3  <= sign2;
            nstep3 <= sprod2[22:6];
            // III apply sign
            dlt4   <= sign3 ? -$signed({2'b00, dlt3}) : $signed({2'b00, dlt3});
            nstep4 <= nstep3;
            // IV add in 18 bits so stage V sees the true sum
            sum5   <= $signed({{2{x4[15]}}, x4}) + dlt4;
            nstep5 <= nstep4;
        end
    end

    // ring registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x1    <= '0;
            x2    <= '0;
            x3    <= '0;
            x4    <= '0;
            x5    <= '0;
            x6    <= '0;
            step1 <= adpcmb_pkg::step_t'(adpcmb_pkg::step_init);
            step2 <= adpcmb_pkg::step_t'(adpcmb_pkg::step_init);
            step3 <= adpcmb_pkg::step_t'(adpcmb_pkg::step_init);
            step4 <= adpcmb_pkg::step_t'(adpcmb_pkg::step_init);
            step5 <= adpcmb_pkg::step_t'(adpcmb_pkg::step_init);
            step6 <= adpcmb_pkg::step_t'(adpcmb_pkg::step_init);
            chon2 <= 1'b0;
            chon3 <= 1'b0;
            chon4 <= 1'b0;
            chon5 <= 1'b0;
        end else if (cen) begin
            x2    <= x1;                 // stages I..IV just carry the state
            x3    <= x2;
            x4    <= x3;
            x5    <= x4;
            step2 <= step1;
            step3 <= step2;
            step4 <= step3;
            step5 <= step4;
            chon2 <= chon;
            chon3 <= chon2;
            chon4 <= chon3;
            chon5 <= chon4;
            // V saturate and clamp, hold, or reset
            if (!chon5) begin
                x6    <= '0;
                step6 <= adpcmb_pkg::step_t'(adpcmb_pkg::step_init);
            end else if (adv) begin
                // overflow can only go the way of the code sign
                if (sum5 > adpcmb_pkg::pcm_max)
                    x6 <= adpcmb_pkg::pcm_t'(adpcmb_pkg::pcm_max);
                else if (sum5 < adpcmb_pkg::pcm_min)
                    x6 <= adpcmb_pkg::pcm_t'(adpcmb_pkg::pcm_min);
                else
                    x6 <= sum5[15:0];
                if (nstep5 < 17'(adpcmb_pkg::step_min))
                    step6 <= adpcmb_pkg::step_t'(adpcmb_pkg::step_min);
                else if (nstep5 > 17'(adpcmb_pkg::step_max))
                    step6 <= adpcmb_pkg::step_t'(adpcmb_pkg::step_max);
                else
                    step6 <= nstep5[14:0];
            end else begin
                x6    <= x5;             // no new nibble this frame
                step6 <= step5;
            end
            // VI close the loop
            x1    <= x6;
            step1 <= step6;
        end
    end

    assign pcm = x6;                     // valid the cen cycle after adv

endmodule

// File: rtl/adpcmb_sequencer.sv
// adpcmb sequencer
// frame phase, delta-n rate, nibble fetch from sample memory and end/loop control
`timescale 1ns/1ps

module adpcmb_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  logic                start,        // pulse, only taken when idle
    input  logic                repeat_en,
    input  adpcmb_pkg::addr_t   start_addr,
    input  adpcmb_pkg::addr_t   end_addr,     // inclusive
    input  adpcmb_pkg::rate_t   delta_n,
    input  adpcmb_pkg::byte_t   mem_data,
    output adpcmb_pkg::addr_t   mem_addr,
    output adpcmb_pkg::nibble_t code,
    output logic                chon,
    output logic                adv,
    output logic                sample_valid,
    output logic                busy,
    output logic                end_pulse
);

    adpcmb_pkg::seq_state_t state;
    logic [2:0]             phase;            // 0..frame_len-1
    adpcmb_pkg::rate_t      acc;
    logic                   adv_pend;         // carry seen at phase 0
    adpcmb_pkg::byte_t      cur_byte;
    logic                   half;             // 0 high nibble, 1 low nibble
    logic                   last_byte;        // cur_byte sits at end_addr
    logic                   fetch_wait;       // memory not settled yet

    // mem_addr points at the byte after cur_byte once its high nibble is gone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= adpcmb_pkg::st_idle;
            phase        <= '0;
            acc          <= '0;
            adv_pend     <= 1'b0;
            adv          <= 1'b0;
            sample_valid <= 1'b0;
            end_pulse    <= 1'b0;
            mem_addr     <= '0;
            cur_byte     <= '0;
            half         <= 1'b0;
            last_byte    <= 1'b0;
            fetch_wait   <= 1'b0;
        end else if (cen) begin
            if (phase == 3'(adpcmb_pkg::frame_len - 1))
                phase <= '0;
            else
                phase <= phase + 3'd1;
            // adv lands in phase 4, sample_valid and end_pulse in phase 5
            adv          <= (state == adpcmb_pkg::st_play) && adv_pend &&
                            (phase == 3'(adpcmb_pkg::adv_phase - 1));
            sample_valid <= adv;
            end_pulse    <= adv && half && last_byte;

            case (state)
                adpcmb_pkg::st_idle: begin
                    if (start) begin
                        mem_addr   <= start_addr;
                        acc        <= '0;
                        adv_pend   <= 1'b0;
                        fetch_wait <= 1'b1;
                        state      <= adpcmb_pkg::st_fetch;
                    end
                end
                adpcmb_pkg::st_fetch: begin
                    fetch_wait <= 1'b0;
                    // needs one cen cycle after the address load
                    if (phase == 3'(adpcmb_pkg::frame_len - 1) && !fetch_wait) begin
                        cur_byte <= mem_data;
                        half     <= 1'b0;
                        state    <= adpcmb_pkg::st_play;
                    end
                end
                adpcmb_pkg::st_play: begin
                    if (phase == 3'd0)
                        {adv_pend, acc} <= {1'b0, acc} + {1'b0, delta_n};
                    if (sample_valid) begin      // only high in phase 5
                        if (!half) begin
                            half      <= 1'b1;
                            last_byte <= (mem_addr == end_addr);
                            // prefetch next byte, wrap keeps the address in range
                            if (mem_addr == end_addr)
                                mem_addr <= start_addr;
                            else
                                mem_addr <= mem_addr + 16'd1;
                        end else begin
                            half <= 1'b0;
                            if (last_byte && !repeat_en)
                                state <= adpcmb_pkg::st_idle;
                            else
                                cur_byte <= mem_data;  // settled a frame ago
                        end
                    end
                end
                default: state <= adpcmb_pkg::st_idle;
            endcase
        end
    end

    assign code = half ? cur_byte[3:0] : cur_byte[7:4];  // moves only at phase 5
    assign chon = (state == adpcmb_pkg::st_play);
    assign busy = chon;

endmodule

// File: rtl/adpcmb_player.sv
// adpcmb single channel player
// sequencer drives the decoder ring slot 0 from external sample memory
`timescale 1ns/1ps

module adpcmb_player (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  logic              start,
    input  logic              repeat_en,
    input  adpcmb_pkg::addr_t start_addr,
    input  adpcmb_pkg::addr_t end_addr,
    input  adpcmb_pkg::rate_t delta_n,
    output adpcmb_pkg::addr_t mem_addr,
    input  adpcmb_pkg::byte_t mem_data,   // one clock after mem_addr
    output adpcmb_pkg::pcm_t  pcm,
    output logic              sample_valid,
    output logic              busy,
    output logic              end_pulse
);

    adpcmb_pkg::nibble_t code;
    logic                chon;
    logic                adv;

    adpcmb_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen          (cen),
        .start        (start),
        .repeat_en    (repeat_en),
        .start_addr   (start_addr),
        .end_addr     (end_addr),
        .delta_n      (delta_n),
        .mem_data     (mem_data),
        .mem_addr     (mem_addr),
        .code         (code),
        .chon         (chon),
        .adv          (adv),
        .sample_valid (sample_valid),
        .busy         (busy),
        .end_pulse    (end_pulse)
    );

    adpcmb_decode u_dec (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .code  (code),
        .chon  (chon),
        .adv   (adv),
        .pcm   (pcm)
    );

endmodule

// File: tb/adpcmb_player_properties.sv
// adpcmb sequencer properties
// frame timing of the strobes and sample memory address range
`timescale 1ns/1ps

module adpcmb_player_properties (
    input logic              clk,
    input logic              rst_n,
    input logic              cen,
    input logic [2:0]        phase,
    input logic              chon,
    input logic              adv,
    input logic              sample_valid,
    input logic              busy,
    input logic              end_pulse,
    input adpcmb_pkg::addr_t mem_addr,
    input adpcmb_pkg::addr_t start_addr,
    input adpcmb_pkg::addr_t end_addr
);

    int n_fail = 0;                      // assertion failures so far

    adv_slot: assert property (@(posedge clk) disable iff (!rst_n)
        adv |-> (phase == 3'(adpcmb_pkg::adv_phase) && chon))
        else begin
            n_fail++;
            $error("adv outside phase 4 or with the channel off");
        end

    // pcm is valid one cen cycle after adv
    valid_after_adv: assert property (@(posedge clk) disable iff (!rst_n)
        (cen && adv) |=> sample_valid)
        else begin
            n_fail++;
            $error("sample_valid missing after adv");
        end

    addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> (mem_addr >= start_addr && mem_addr <= end_addr))
        else begin
            n_fail++;
            $error("mem_addr left the sample range while busy");
        end

    end_slot: assert property (@(posedge clk) disable iff (!rst_n)
        end_pulse |-> (phase == 3'(adpcmb_pkg::frame_len - 1)))
        else begin
            n_fail++;
            $error("end_pulse outside phase 5");
        end

endmodule

bind adpcmb_sequencer adpcmb_player_properties u_props (.*);

// File: tb/tb_adpcmb_player.sv
// testbench for the adpcmb player
// random and directed sample streams checked against a reference decoder
`timescale 1ns/1ps

module tb_adpcmb_player;

    localparam int total_samples = 416;      // sum over all runs below
    localparam int max_fps       = 16;       // 65536 / smallest delta_n

    logic                clk;
    logic                rst_n;
    logic                cen;
    logic                start;
    logic                repeat_en;
    adpcmb_pkg::addr_t   start_addr;
    adpcmb_pkg::addr_t   end_addr;
    adpcmb_pkg::rate_t   delta_n;
    adpcmb_pkg::addr_t   mem_addr;
    adpcmb_pkg::byte_t   mem_data;
    adpcmb_pkg::pcm_t    pcm;
    logic                sample_valid;
    logic                busy;
    logic                end_pulse;

    adpcmb_pkg::byte_t   mem [0:65535];
    adpcmb_pkg::pcm_t    exp_q [$];          // expected samples, oldest first
    adpcmb_pkg::pcm_t    max_seen, min_seen;
    string               test_name;
    int                  n_samples, n_ends;
    int                  n_val_err, n_other_err;
    logic                cen_rand;           // gaps in cen when high
    logic [1:0]          grp;
    int                  gap;

    adpcmb_player DUT (.*);

    always #2 clk = ~clk;                    // 4 ns period

    // sample memory, one clock registered read
    always @(posedge clk)
        mem_data <= mem[mem_addr];

    // one random hole in every group of four clocks
    always @(posedge clk) begin
        if (cen_rand) begin
            if (grp == 2'd0)
                gap = $urandom % 4;
            cen <= (int'(grp) != gap);
            grp <= grp + 2'd1;
        end else begin
            cen <= 1'b1;
        end
    end

    // next sample and step for one code
    function automatic void ref_decode(input adpcmb_pkg::pcm_t x, input adpcmb_pkg::step_t st,
                                       input adpcmb_pkg::nibble_t c,
                                       output adpcmb_pkg::pcm_t x_nxt,
                                       output adpcmb_pkg::step_t st_nxt);
        int dlt;
        int sum;
        int mul;
        int ns;
        dlt = ((2 * int'(c[2:0]) + 1) * int'(st)) / 8;     // odd magnitude
        sum = c[3] ? int'(x) - dlt : int'(x) + dlt;
        if (sum > adpcmb_pkg::pcm_max)
            sum = adpcmb_pkg::pcm_max;
        else if (sum < adpcmb_pkg::pcm_min)
            sum = adpcmb_pkg::pcm_min;
        mul = c[2] ? int'(adpcmb_pkg::step_mul[c[1:0]]) : int'(adpcmb_pkg::step_mul_lo);
        ns  = mul * int'(st) / 64;
        if (ns < adpcmb_pkg::step_min)
            ns = adpcmb_pkg::step_min;
        else if (ns > adpcmb_pkg::step_max)
            ns = adpcmb_pkg::step_max;
        x_nxt  = adpcmb_pkg::pcm_t'(sum);
        st_nxt = adpcmb_pkg::step_t'(ns);
    endfunction

    // carries out of the rate accumulator over a number of frames
    function automatic int adv_count(input adpcmb_pkg::rate_t dn, input int frames);
        logic [16:0] s;
        adpcmb_pkg::rate_t acc;
        int n;
        acc = '0;
        n   = 0;
        for (int k = 0; k < frames; k++) begin
            s   = {1'b0, acc} + {1'b0, dn};
            n  += int'(s[16]);
            acc = s[15:0];
        end
        return n;
    endfunction

    task automatic check_pcm(input string name, input adpcmb_pkg::pcm_t exp,
                             input adpcmb_pkg::pcm_t act);
        if (exp !== act) begin
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
            n_val_err++;
        end
    endtask

    task automatic check_addr(input string name, input adpcmb_pkg::addr_t exp,
                              input adpcmb_pkg::addr_t act);
        if (exp !== act) begin
            $display("Error %s: expected %04h, actual %04h", name, exp, act);
            n_val_err++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
            n_val_err++;
        end
    endtask

    // one run over sa..ea, frames > 0 also counts samples in the first frames
    task automatic play(input string name, input adpcmb_pkg::addr_t sa,
                        input adpcmb_pkg::addr_t ea, input adpcmb_pkg::rate_t dn,
                        input int passes, input int frames);
        adpcmb_pkg::pcm_t  x;
        adpcmb_pkg::step_t st;
        int n;
        int got;
        int ends;
        x  = '0;
        st = adpcmb_pkg::step_t'(adpcmb_pkg::step_init);
        for (int p = 0; p < passes; p++)
            for (int a = int'(sa); a <= int'(ea); a++)
                for (int h = 1; h >= 0; h--) begin           // high nibble first
                    ref_decode(x, st, mem[a][h*4 +: 4], x, st);
                    exp_q.push_back(x);
                end
        test_name  = name;
        n_samples  = 0;
        n_ends     = 0;
        max_seen   = adpcmb_pkg::pcm_t'(adpcmb_pkg::pcm_min);
        min_seen   = adpcmb_pkg::pcm_t'(adpcmb_pkg::pcm_max);
        start_addr <= sa;
        end_addr   <= ea;
        delta_n    <= dn;
        repeat_en  <= (passes > 1);
        start      <= 1'b1;                  // held until the channel is up
        do @(posedge clk); while (!busy);
        n    = 0;
        got  = 0;
        ends = 0;
        while (busy) begin
            start <= 1'b0;
            if (cen) begin
                n++;                         // first counted cycle is phase 0
                if (sample_valid && n <= frames * adpcmb_pkg::frame_len)
                    got++;
                if (end_pulse) begin
                    ends++;
                    if (ends == passes - 1)
                        repeat_en <= 1'b0;   // last pass follows
                    if (ends == 1 && passes > 1)
                        start <= 1'b1;       // stray start while busy
                end
            end
            @(posedge clk);
        end
        if (frames > 0)
            check_count({name, " frame samples"}, adv_count(dn, frames), got);
        check_count({name, " samples"}, 2 * passes * (int'(ea) - int'(sa) + 1), n_samples);
        check_count({name, " end pulses"}, passes, n_ends);
        check_count({name, " leftover"}, 0, exp_q.size());
        check_addr({name, " stop address"}, sa, mem_addr);
        exp_q.delete();
    endtask

    // compare each sample as it comes out
    always @(posedge clk) begin
        if (rst_n && cen && sample_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: sample_valid came with no sample expected", test_name);
                n_other_err++;
            end else begin
                check_pcm(test_name, exp_q.pop_front(), pcm);
            end
            n_samples++;
            if (pcm > max_seen)
                max_seen = pcm;
            if (pcm < min_seen)
                min_seen = pcm;
        end
        if (rst_n && cen && end_pulse)
            n_ends++;
    end

    initial begin
        void'($urandom(32'h909b4e58));
        clk         = 1'b0;
        rst_n       = 1'b0;
        cen         = 1'b1;
        start       = 1'b0;
        repeat_en   = 1'b0;
        start_addr  = '0;
        end_addr    = '0;
        delta_n     = '0;
        mem_data    = '0;
        cen_rand    = 1'b0;
        grp         = '0;
        n_val_err   = 0;
        n_other_err = 0;
        for (int i = 0; i < 65536; i++)
            mem[i] = adpcmb_pkg::byte_t'($urandom);
        // +7 runs up to the top, -7 down to the bottom, then 0 pulls the step back
        for (int i = 0; i < 80; i++)
            mem[16'h0200 + i] = (i < 24) ? 8'h77 : (i < 48) ? 8'hff : 8'h00;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        play("random stream", 16'h0100, 16'h010f, 16'hffff, 1, 24);
        play("saturation", 16'h0200, 16'h024f, 16'hffff, 1, 0);
        check_pcm("saturation top", adpcmb_pkg::pcm_t'(adpcmb_pkg::pcm_max), max_seen);
        check_pcm("saturation bottom", adpcmb_pkg::pcm_t'(adpcmb_pkg::pcm_min), min_seen);
        play("rate 32768", 16'h0100, 16'h010f, 16'd32768, 1, 24);
        play("rate 20000", 16'h0100, 16'h010f, 16'd20000, 1, 24);
        play("rate 4096", 16'h0100, 16'h010f, 16'd4096, 1, 24);
        play("stop", 16'h0300, 16'h0307, 16'hffff, 1, 0);
        play("restart", 16'h0300, 16'h0307, 16'hffff, 1, 0);
        play("repeat", 16'h0300, 16'h0307, 16'd40000, 3, 0);
        cen_rand <= 1'b1;
        play("cen gaps stream", 16'h0100, 16'h010f, 16'hffff, 1, 24);
        play("cen gaps stop", 16'h0300, 16'h0307, 16'hffff, 1, 0);
        n_other_err += DUT.u_seq.u_props.n_fail;   // bound assertion failures
        $display("errors: %0d value, %0d other", n_val_err, n_other_err);
        if (n_val_err == 0 && n_other_err == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // factor 2 leaves room for the cen holes
    initial begin
        #(total_samples * max_fps * adpcmb_pkg::frame_len * 4 * 2 + 10000);
        $display("timeout: the runs did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: adpcmb.f
rtl/adpcmb_pkg.sv
rtl/adpcmb_decode.sv
rtl/adpcmb_sequencer.sv
rtl/adpcmb_player.sv
tb/adpcmb_player_properties.sv
tb/tb_adpcmb_player.sv

// File: Makefile
# Verilator build and run of the adpcmb player testbench

TOP       ?= tb_adpcmb_player
FILELIST  ?= adpcmb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: TOP FILELIST OBJ_DIR LOG SEED VERILATOR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
